/* tb.f */
+incdir+source
source/gpu_pkg.sv
source/axi_lite_slave.sv
source/tile_ram.sv
source/vga_timing.sv
source/pixel_pipe.sv
source/gpu_top.sv
sim/tb_clock.sv
sim/tb_gpu.sv

/* run.sh */
#!/bin/sh
# Build the GPU testbench with Verilator, run it, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_gpu -o sim_gpu &&
  ./obj_dir/sim_gpu > sim.log 2>&1 || echo "Build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qs "Test completed successfully" sim.log && exit 0 || exit 1

/* sim/tb_gpu.sv */
`timescale 1ns/1ns
`include "gpu_config.svh"

module tb_gpu;

  import gpu_pkg::*;

  localparam int AW = `GPU_ADDR_WIDTH;
  localparam int DW = `GPU_DATA_WIDTH;
  localparam int LINE_CYCLES = `GPU_H_ACTIVE + `GPU_H_FP + `GPU_H_SYNC + `GPU_H_BP;
  localparam int FRAME_LINES = `GPU_V_ACTIVE + `GPU_V_FP + `GPU_V_SYNC + `GPU_V_BP;
  localparam int FRAME_CYCLES = LINE_CYCLES * FRAME_LINES;
  localparam int ACTIVE_PIXELS = `GPU_H_ACTIVE * `GPU_V_ACTIVE;
  // Five frames of raster checks, one spare frame, and the bus traffic
  localparam int TIMEOUT_CYCLES = 6 * FRAME_CYCLES + 4000;
  localparam logic [AW-1:0] ADDR_UNMAPPED = AW'('h100);

  logic          Clk;
  logic          rst_n;
  logic [AW-1:0] s_axi_awaddr;
  logic [2:0]    s_axi_awprot;
  logic          s_axi_awvalid;
  logic          s_axi_awready;
  logic [DW-1:0] s_axi_wdata;
  logic [3:0]    s_axi_wstrb;
  logic          s_axi_wvalid;
  logic          s_axi_wready;
  logic [1:0]    s_axi_bresp;
  logic          s_axi_bvalid;
  logic          s_axi_bready;
  logic [AW-1:0] s_axi_araddr;
  logic [2:0]    s_axi_arprot;
  logic          s_axi_arvalid;
  logic          s_axi_arready;
  logic [DW-1:0] s_axi_rdata;
  logic [1:0]    s_axi_rresp;
  logic          s_axi_rvalid;
  logic          s_axi_rready;
  logic [3:0]    red;
  logic [3:0]    green;
  logic [3:0]    blue;
  logic          hsync;
  logic          vsync;
  logic          vde;

  // Model of what the tile memory and BG_COLOR should hold
  logic [11:0] tile_colors [`GPU_TILE_COUNT];
  logic [11:0] bg_expected;
  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;

  tb_clock #(.PERIOD(10), .RESET_CYCLES(8)) clk_gen (.Clk(Clk), .rst_n(rst_n));

  gpu_top DUT (
    .Clk(Clk), .rst_n(rst_n),
    .s_axi_awaddr(s_axi_awaddr), .s_axi_awprot(s_axi_awprot),
    .s_axi_awvalid(s_axi_awvalid), .s_axi_awready(s_axi_awready),
    .s_axi_wdata(s_axi_wdata), .s_axi_wstrb(s_axi_wstrb),
    .s_axi_wvalid(s_axi_wvalid), .s_axi_wready(s_axi_wready),
    .s_axi_bresp(s_axi_bresp), .s_axi_bvalid(s_axi_bvalid), .s_axi_bready(s_axi_bready),
    .s_axi_araddr(s_axi_araddr), .s_axi_arprot(s_axi_arprot),
    .s_axi_arvalid(s_axi_arvalid), .s_axi_arready(s_axi_arready),
    .s_axi_rdata(s_axi_rdata), .s_axi_rresp(s_axi_rresp),
    .s_axi_rvalid(s_axi_rvalid), .s_axi_rready(s_axi_rready),
    .red(red), .green(green), .blue(blue),
    .hsync(hsync), .vsync(vsync), .vde(vde)
  );

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic axi_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                           input logic [3:0] strb, input logic [1:0] exp_resp);
    logic [1:0] resp;
    @(negedge Clk);
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    s_axi_bready  = 1'b1;
    while (!(s_axi_awready && s_axi_wready)) @(negedge Clk);
    // Address and data are taken on the next rising edge
    @(negedge Clk);
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    while (!s_axi_bvalid) @(negedge Clk);
    resp = s_axi_bresp;
    @(negedge Clk);
    s_axi_bready = 1'b0;
    compare_value("s_axi_bresp", 32'(resp), 32'(exp_resp));
  endtask

  task automatic axi_read(input logic [AW-1:0] addr, input logic [1:0] exp_resp,
                          output logic [DW-1:0] data);
    @(negedge Clk);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    s_axi_rready  = 1'b0;
    while (!s_axi_arready) @(negedge Clk);
    @(negedge Clk);
    s_axi_arvalid = 1'b0;
    while (!s_axi_rvalid) @(negedge Clk);
    data = s_axi_rdata;
    compare_value("s_axi_rresp", 32'(s_axi_rresp), 32'(exp_resp));
    // Hold rready low one cycle so rdata has to stay put
    @(negedge Clk);
    compare_value("s_axi_rvalid", 32'(s_axi_rvalid), 32'd1);
    compare_value("s_axi_rdata", s_axi_rdata, data);
    s_axi_rready = 1'b1;
    @(negedge Clk);
    s_axi_rready = 1'b0;
  endtask

  task automatic wait_vsync_fall();
    logic prev;
    prev = vsync;
    @(negedge Clk);
    while (!(prev && !vsync)) begin
      prev = vsync;
      @(negedge Clk);
    end
  endtask

  // Walks one frame from vsync fall to vsync fall
  // Pixel x and y come from the running vde count
  task automatic check_frame(input logic tiles_on, input logic [11:0] bg);
    int          cycles;
    int          pixels;
    int          hs_falls;
    int          shown;
    int          x;
    int          y;
    logic        prev_hs;
    logic        prev_vs;
    logic        done;
    logic [7:0]  tile_idx;
    logic [11:0] exp;
    logic [11:0] got;
    cycles   = 0;
    pixels   = 0;
    hs_falls = 0;
    shown    = 0;
    prev_hs  = 1'b1;
    done     = 1'b0;
    wait_vsync_fall();
    while (!done) begin
      got = {red, green, blue};
      if (vde) begin
        x = pixels % `GPU_H_ACTIVE;
        y = (pixels / `GPU_H_ACTIVE) % `GPU_V_ACTIVE;
        tile_idx = 8'((y >> `GPU_TILE_SHIFT) * `GPU_TILE_COLS + (x >> `GPU_TILE_SHIFT));
        exp = tiles_on ? tile_colors[tile_idx] : bg;
        pixels++;
      end else begin
        exp = '0;
      end
      check_count++;
      assert (got === exp) else begin
        error_count++;
        if (shown < 8) begin
          $display("[ERROR] rgb at frame cycle %0d (vde %0b): got 0x%h, expected 0x%h",
                   cycles, vde, got, exp);
        end
        shown++;
      end
      if (prev_hs && !hsync) hs_falls++;
      prev_hs = hsync;
      prev_vs = vsync;
      cycles++;
      @(negedge Clk);
      done = prev_vs && !vsync;
    end
    compare_value("frame cycles", cycles, FRAME_CYCLES);
    compare_value("hsync pulses", hs_falls, FRAME_LINES);
    compare_value("vde cycles", pixels, ACTIVE_PIXELS);
  endtask

  task automatic reset_defaults();
    logic [DW-1:0] data;
    compare_value("red", 32'(red), 32'd0);
    compare_value("green", 32'(green), 32'd0);
    compare_value("blue", 32'(blue), 32'd0);
    compare_value("vde", 32'(vde), 32'd0);
    compare_value("hsync", 32'(hsync), 32'd1);
    compare_value("vsync", 32'(vsync), 32'd1);
    compare_value("s_axi_awready", 32'(s_axi_awready), 32'd0);
    compare_value("s_axi_wready", 32'(s_axi_wready), 32'd0);
    compare_value("s_axi_bvalid", 32'(s_axi_bvalid), 32'd0);
    compare_value("s_axi_arready", 32'(s_axi_arready), 32'd0);
    compare_value("s_axi_rvalid", 32'(s_axi_rvalid), 32'd0);
    axi_read(REG_CTRL, RESP_OKAY, data);
    compare_value("CTRL", data, 32'd0);
    axi_read(REG_BG_COLOR, RESP_OKAY, data);
    compare_value("BG_COLOR", data, 32'd0);
  endtask

  task automatic register_access();
    logic [DW-1:0] data;
    logic [11:0]   color;
    logic [11:0]   low;
    color = 12'($urandom);
    axi_write(REG_BG_COLOR, 32'(color), 4'hf, RESP_OKAY);
    axi_read(REG_BG_COLOR, RESP_OKAY, data);
    compare_value("BG_COLOR", data, 32'(color));
    // Low strobe only leaves the red nibble alone
    low = 12'($urandom);
    axi_write(REG_BG_COLOR, 32'(low), 4'b0001, RESP_OKAY);
    bg_expected = {color[11:8], low[7:0]};
    axi_read(REG_BG_COLOR, RESP_OKAY, data);
    compare_value("BG_COLOR", data, 32'(bg_expected));
    axi_write(REG_STATUS, 32'hffff_ffff, 4'hf, RESP_SLVERR);
    // Raster is still in the first active area of the first frame
    axi_read(REG_STATUS, RESP_OKAY, data);
    compare_value("STATUS", data, 32'd0);
    axi_write(ADDR_UNMAPPED, 32'h0000_0fff, 4'hf, RESP_SLVERR);
    axi_read(ADDR_UNMAPPED, RESP_SLVERR, data);
    compare_value("unmapped rdata", data, 32'd0);
    axi_read(REG_CTRL, RESP_OKAY, data);
    compare_value("CTRL", data, 32'd0);
    axi_read(REG_BG_COLOR, RESP_OKAY, data);
    compare_value("BG_COLOR", data, 32'(bg_expected));
  endtask

  task automatic tile_memory_readback();
    logic [DW-1:0] data;
    for (int n = 0; n < `GPU_TILE_COUNT; n++) begin
      tile_colors[8'(n)] = 12'($urandom);
      axi_write(AW'(`GPU_VRAM_BASE + 4 * n), 32'(tile_colors[8'(n)]), 4'hf, RESP_OKAY);
    end
    for (int n = 0; n < `GPU_TILE_COUNT; n++) begin
      axi_read(AW'(`GPU_VRAM_BASE + 4 * n), RESP_OKAY, data);
      compare_value($sformatf("VRAM[%0d]", n), data, 32'(tile_colors[8'(n)]));
    end
  endtask

  // Starts at the vsync fall that ends the previous frame check
  task automatic frame_count_step();
    logic [DW-1:0] data;
    logic [DW-1:0] first;
    axi_read(REG_STATUS, RESP_OKAY, first);
    compare_value("STATUS vblank", 32'(first[16]), 32'd1);
    compare_value("STATUS upper bits", 32'(first[31:17]), 32'd0);
    wait_vsync_fall();
    axi_read(REG_STATUS, RESP_OKAY, data);
    compare_value("STATUS frame count", 32'(data[15:0]), 32'(first[15:0] + 16'd1));
  endtask

  task automatic tile_frame_colors();
    axi_write(REG_CTRL, 32'd1, 4'hf, RESP_OKAY);
    check_frame(1'b1, bg_expected);
  endtask

  always @(posedge Clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycle_count);
      $display("Checks run: %0d, errors: %0d", check_count, error_count + 1);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(85));
    s_axi_awaddr  = '0;
    s_axi_awprot  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arprot  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    bg_expected   = '0;
    @(posedge rst_n);
    reset_defaults();
    register_access();
    tile_memory_readback();
    check_frame(1'b0, bg_expected);
    frame_count_step();
    tile_frame_colors();
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 8
) (
  output logic Clk,
  output logic rst_n
);

  initial begin
    Clk = 1'b0;
    forever #(PERIOD / 2) Clk = ~Clk;
  end

  // Release on a falling edge, away from the DUT's sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge Clk);
    @(negedge Clk);
    rst_n = 1'b1;
  end

endmodule

/* source/gpu_top.sv */
`timescale 1ns/1ns
`include "gpu_config.svh"

module gpu_top (
  input  logic                         Clk,
  input  logic                         rst_n,
  input  logic [`GPU_ADDR_WIDTH-1:0]   s_axi_awaddr,
  input  logic [2:0]                   s_axi_awprot,
  input  logic                         s_axi_awvalid,
  output logic                         s_axi_awready,
  input  logic [`GPU_DATA_WIDTH-1:0]   s_axi_wdata,
  input  logic [`GPU_DATA_WIDTH/8-1:0] s_axi_wstrb,
  input  logic                         s_axi_wvalid,
  output logic                         s_axi_wready,
  output logic [1:0]                   s_axi_bresp,
  output logic                         s_axi_bvalid,
  input  logic                         s_axi_bready,
  input  logic [`GPU_ADDR_WIDTH-1:0]   s_axi_araddr,
  input  logic [2:0]                   s_axi_arprot,
  input  logic                         s_axi_arvalid,
  output logic                         s_axi_arready,
  output logic [`GPU_DATA_WIDTH-1:0]   s_axi_rdata,
  output logic [1:0]                   s_axi_rresp,
  output logic                         s_axi_rvalid,
  input  logic                         s_axi_rready,
  output logic [3:0]                   red,
  output logic [3:0]                   green,
  output logic [3:0]                   blue,
  output logic                         hsync,
  output logic                         vsync,
  output logic                         vde
);

  // awprot and arprot are accepted but carry no meaning here
  logic        ram_we;
  logic [7:0]  ram_addr;
  logic [11:0] ram_wdata;
  logic [11:0] ram_rdata;
  logic        enable;
  logic [11:0] bg_color;
  logic [9:0]  draw_x, draw_y;
  logic        hs_raw, vs_raw, de_raw;
  logic        vblank;
  logic [15:0] frame_count;
  logic [7:0]  tile_addr;
  logic [11:0] tile_color;

  axi_lite_slave regs (
    .Clk(Clk), .rst_n(rst_n),
    .s_axi_awaddr(s_axi_awaddr), .s_axi_awvalid(s_axi_awvalid), .s_axi_awready(s_axi_awready),
    .s_axi_wdata(s_axi_wdata), .s_axi_wstrb(s_axi_wstrb), .s_axi_wvalid(s_axi_wvalid),
    .s_axi_wready(s_axi_wready),
    .s_axi_bresp(s_axi_bresp), .s_axi_bvalid(s_axi_bvalid), .s_axi_bready(s_axi_bready),
    .s_axi_araddr(s_axi_araddr), .s_axi_arvalid(s_axi_arvalid), .s_axi_arready(s_axi_arready),
    .s_axi_rdata(s_axi_rdata), .s_axi_rresp(s_axi_rresp), .s_axi_rvalid(s_axi_rvalid),
    .s_axi_rready(s_axi_rready),
    .frame_count(frame_count), .vblank(vblank),
    .ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_rdata(ram_rdata),
    .enable(enable), .bg_color(bg_color)
  );

  tile_ram vram (
    .Clk(Clk),
    .a_we(ram_we), .a_addr(ram_addr), .a_wdata(ram_wdata), .a_rdata(ram_rdata),
    .b_addr(tile_addr), .b_rdata(tile_color)
  );

  // VGA sync generator, one pixel per Clk
  vga_timing #(
    .H_ACTIVE(`GPU_H_ACTIVE), .H_FP(`GPU_H_FP), .H_SYNC(`GPU_H_SYNC), .H_BP(`GPU_H_BP),
    .V_ACTIVE(`GPU_V_ACTIVE), .V_FP(`GPU_V_FP), .V_SYNC(`GPU_V_SYNC), .V_BP(`GPU_V_BP)
  ) vga (
    .Clk(Clk), .rst_n(rst_n),
    .draw_x(draw_x), .draw_y(draw_y),
    .hs_raw(hs_raw), .vs_raw(vs_raw), .de_raw(de_raw),
    .vblank(vblank), .frame_count(frame_count)
  );

  pixel_pipe pix (
    .Clk(Clk), .rst_n(rst_n),
    .draw_x(draw_x), .draw_y(draw_y),
    .hs_raw(hs_raw), .vs_raw(vs_raw), .de_raw(de_raw),
    .enable(enable), .bg_color(bg_color), .tile_color(tile_color),
    .tile_addr(tile_addr),
    .red(red), .green(green), .blue(blue),
    .hsync(hsync), .vsync(vsync), .vde(vde)
  );

endmodule

/* source/pixel_pipe.sv */
`timescale 1ns/1ns
`include "gpu_config.svh"

module pixel_pipe (
  input  logic            Clk,
  input  logic            rst_n,
  input  gpu_pkg::coord_t draw_x,
  input  gpu_pkg::coord_t draw_y,
  input  logic            hs_raw,
  input  logic            vs_raw,
  input  logic            de_raw,
  input  logic            enable,
  input  gpu_pkg::rgb_t   bg_color,
  input  gpu_pkg::rgb_t   tile_color,
  output logic [7:0]      tile_addr,
  output logic [3:0]      red,
  output logic [3:0]      green,
  output logic [3:0]      blue,
  output logic            hsync,
  output logic            vsync,
  output logic            vde
);

  import gpu_pkg::*;

  coord_t tile_row;
  coord_t tile_col;
  logic   hs_d1;
  logic   vs_d1;
  logic   de_d1;
  rgb_t   pix_color;

  // Stage 1: tile index goes straight to the RAM address register
  assign tile_row  = draw_y >> `GPU_TILE_SHIFT;
  assign tile_col  = draw_x >> `GPU_TILE_SHIFT;
  assign tile_addr = 8'(tile_row * `GPU_TILE_COLS + tile_col);

  always_ff @(posedge Clk) begin
    if (!rst_n) begin
      hs_d1 <= 1'b1;
      vs_d1 <= 1'b1;
      de_d1 <= 1'b0;
    end else begin
      hs_d1 <= hs_raw;
      vs_d1 <= vs_raw;
      de_d1 <= de_raw;
    end
  end

  // Stage 2: tile_color lines up with de_d1 here
  always_comb begin
    if (!de_d1) begin
      pix_color = '0;
    end else if (enable) begin
      pix_color = tile_color;
    end else begin
      pix_color = bg_color;
    end
  end

  always_ff @(posedge Clk) begin
    if (!rst_n) begin
      {red, green, blue} <= '0;
      hsync <= 1'b1;
      vsync <= 1'b1;
      vde   <= 1'b0;
    end else begin
      {red, green, blue} <= pix_color;
      hsync <= hs_d1;
      vsync <= vs_d1;
      vde   <= de_d1;
    end
  end

endmodule

/* source/vga_timing.sv */
`timescale 1ns/1ns
`include "gpu_config.svh"

module vga_timing #(
  parameter int H_ACTIVE = `GPU_H_ACTIVE,
  parameter int H_FP     = `GPU_H_FP,
  parameter int H_SYNC   = `GPU_H_SYNC,
  parameter int H_BP     = `GPU_H_BP,
  parameter int V_ACTIVE = `GPU_V_ACTIVE,
  parameter int V_FP     = `GPU_V_FP,
  parameter int V_SYNC   = `GPU_V_SYNC,
  parameter int V_BP     = `GPU_V_BP
) (
  input  logic            Clk,
  input  logic            rst_n,
  output gpu_pkg::coord_t draw_x,
  output gpu_pkg::coord_t draw_y,
  output logic            hs_raw,
  output logic            vs_raw,
  output logic            de_raw,
  output logic            vblank,
  output logic [15:0]     frame_count
);

  import gpu_pkg::*;

  localparam coord_t H_LAST   = coord_t'(H_ACTIVE + H_FP + H_SYNC + H_BP - 1);
  localparam coord_t V_LAST   = coord_t'(V_ACTIVE + V_FP + V_SYNC + V_BP - 1);
  localparam coord_t H_ACT    = coord_t'(H_ACTIVE);
  localparam coord_t V_ACT    = coord_t'(V_ACTIVE);
  localparam coord_t HS_START = coord_t'(H_ACTIVE + H_FP);
  localparam coord_t HS_END   = coord_t'(H_ACTIVE + H_FP + H_SYNC);
  localparam coord_t VS_START = coord_t'(V_ACTIVE + V_FP);
  localparam coord_t VS_END   = coord_t'(V_ACTIVE + V_FP + V_SYNC);

  coord_t h_count;
  coord_t v_count;
  logic   line_end;
  logic   frame_end;

  assign line_end  = (h_count == H_LAST);
  assign frame_end = line_end && (v_count == V_LAST);

  always_ff @(posedge Clk) begin
    if (!rst_n) begin
      h_count     <= '0;
      v_count     <= '0;
      frame_count <= '0;
    end else begin
      if (line_end) begin
        h_count <= '0;
        v_count <= (v_count == V_LAST) ? '0 : v_count + coord_t'(1);
      end else begin
        h_count <= h_count + coord_t'(1);
      end
      if (frame_end) begin
        frame_count <= frame_count + 16'd1;
      end
    end
  end

  assign draw_x = h_count;
  assign draw_y = v_count;

  // Both syncs are active low
  assign hs_raw = !((h_count >= HS_START) && (h_count < HS_END));
  assign vs_raw = !((v_count >= VS_START) && (v_count < VS_END));
  assign de_raw = (h_count < H_ACT) && (v_count < V_ACT);
  assign vblank = (v_count >= V_ACT);

  // Vertical sync only moves at the start of a line
  vsync_on_line_start: assert property (@(posedge Clk) disable iff (!rst_n)
    !$stable(vs_raw) |-> (h_count == '0));

endmodule

/* source/tile_ram.sv */
`timescale 1ns/1ns
`include "gpu_config.svh"

module tile_ram (
  input  logic        Clk,
  input  logic        a_we,
  input  logic [7:0]  a_addr,
  input  logic [11:0] a_wdata,
  output logic [11:0] a_rdata,
  input  logic [7:0]  b_addr,
  output logic [11:0] b_rdata
);

  logic [11:0] mem [`GPU_TILE_COUNT];

  // All tiles start black
  initial begin
    for (int i = 0; i < `GPU_TILE_COUNT; i++) begin
      mem[i] = '0;
    end
  end

  // Port A belongs to the bus
  always @(posedge Clk) begin
    if (a_we) begin
      mem[a_addr] <= a_wdata;
    end
  end

  // Read-first, so a same-cycle write shows up one access later
  always_ff @(posedge Clk) begin
    a_rdata <= mem[a_addr];
  end

  // Port B feeds the pixel pipeline
  always_ff @(posedge Clk) begin
    b_rdata <= mem[b_addr];
  end

endmodule

/* source/axi_lite_slave.sv */
`timescale 1ns/1ns
`include "gpu_config.svh"

module axi_lite_slave (
  input  logic                           Clk,
  input  logic                           rst_n,
  input  logic [`GPU_ADDR_WIDTH-1:0]     s_axi_awaddr,
  input  logic                           s_axi_awvalid,
  output logic                           s_axi_awready,
  input  logic [`GPU_DATA_WIDTH-1:0]     s_axi_wdata,
  input  logic [`GPU_DATA_WIDTH/8-1:0]   s_axi_wstrb,
  input  logic                           s_axi_wvalid,
  output logic                           s_axi_wready,
  output logic [1:0]                     s_axi_bresp,
  output logic                           s_axi_bvalid,
  input  logic                           s_axi_bready,
  input  logic [`GPU_ADDR_WIDTH-1:0]     s_axi_araddr,
  input  logic                           s_axi_arvalid,
  output logic                           s_axi_arready,
  output logic [`GPU_DATA_WIDTH-1:0]     s_axi_rdata,
  output logic [1:0]                     s_axi_rresp,
  output logic                           s_axi_rvalid,
  input  logic                           s_axi_rready,
  input  logic [15:0]                    frame_count,
  input  logic                           vblank,
  output logic                           ram_we,
  output logic [7:0]                     ram_addr,
  output logic [11:0]                    ram_wdata,
  input  logic [11:0]                    ram_rdata,
  output logic                           enable,
  output gpu_pkg::rgb_t                  bg_color
);

  import gpu_pkg::*;

  localparam int AW = `GPU_ADDR_WIDTH;
  localparam int DW = `GPU_DATA_WIDTH;
  localparam logic [AW-1:0] VRAM_LO = AW'(`GPU_VRAM_BASE);
  localparam logic [AW-1:0] VRAM_HI = AW'(`GPU_VRAM_BASE + 4 * `GPU_TILE_COUNT);

  wr_state_e         wr_state;
  rd_state_e         rd_state;
  logic              wr_fire;
  logic              wr_vram;
  logic              aw_start;
  logic              rd_fire;
  logic              rd_vram;
  logic              rd_hit;
  logic              ar_start;
  logic [DW-1:0]     rd_reg_data;

  // Handshake cycles are the cycles where the ready outputs are high
  assign wr_fire = s_axi_awready & s_axi_wready;
  assign rd_fire = s_axi_arready;

  assign wr_vram = (s_axi_awaddr >= VRAM_LO) && (s_axi_awaddr < VRAM_HI);
  assign rd_vram = (s_axi_araddr >= VRAM_LO) && (s_axi_araddr < VRAM_HI);

  // Read gets port A first, so the two handshakes never share a cycle
  assign ar_start = (rd_state == RD_IDLE) && s_axi_arvalid && !s_axi_arready;
  assign aw_start = (wr_state == WR_IDLE) && s_axi_awvalid && s_axi_wvalid &&
                    !s_axi_awready && !ar_start;

  // Tile entries only change on a full 12-bit write
  assign ram_we    = wr_fire && wr_vram && (s_axi_wstrb[1:0] == 2'b11);
  assign ram_addr  = ram_we ? s_axi_awaddr[9:2] : s_axi_araddr[9:2];
  assign ram_wdata = s_axi_wdata[11:0];

  always_comb begin
    rd_hit      = 1'b1;
    rd_reg_data = '0;
    if (s_axi_araddr == REG_CTRL) begin
      rd_reg_data = {{(DW-1){1'b0}}, enable};
    end else if (s_axi_araddr == REG_BG_COLOR) begin
      rd_reg_data = {{(DW-12){1'b0}}, bg_color};
    end else if (s_axi_araddr == REG_STATUS) begin
      rd_reg_data = {{(DW-17){1'b0}}, vblank, frame_count};
    end else if (!rd_vram) begin
      rd_hit = 1'b0;
    end
  end

  // Write channel
  always_ff @(posedge Clk) begin
    if (!rst_n) begin
      wr_state      <= WR_IDLE;
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
      s_axi_bvalid  <= 1'b0;
      s_axi_bresp   <= RESP_OKAY;
      enable        <= 1'b0;
      bg_color      <= '0;
    end else begin
      case (wr_state)
        WR_IDLE: begin
          if (wr_fire) begin
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b1;
            s_axi_bresp   <= RESP_OKAY;
            wr_state      <= WR_RESP;
            if (s_axi_awaddr == REG_CTRL) begin
              if (s_axi_wstrb[0]) enable <= s_axi_wdata[0];
            end else if (s_axi_awaddr == REG_BG_COLOR) begin
              if (s_axi_wstrb[0]) bg_color[7:0] <= s_axi_wdata[7:0];
              if (s_axi_wstrb[1]) bg_color[11:8] <= s_axi_wdata[11:8];
            end else if (!wr_vram) begin
              // STATUS is read-only and lands here too
              s_axi_bresp <= RESP_SLVERR;
            end
          end else if (aw_start) begin
            s_axi_awready <= 1'b1;
            s_axi_wready  <= 1'b1;
          end
        end
        WR_RESP: begin
          if (s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
            wr_state     <= WR_IDLE;
          end
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  // Read channel
  always_ff @(posedge Clk) begin
    if (!rst_n) begin
      rd_state      <= RD_IDLE;
      s_axi_arready <= 1'b0;
      s_axi_rvalid  <= 1'b0;
      s_axi_rresp   <= RESP_OKAY;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (rd_fire) begin
            s_axi_arready <= 1'b0;
            if (rd_vram) begin
              rd_state <= RD_WAIT;
            end else begin
              s_axi_rvalid <= 1'b1;
              s_axi_rresp  <= rd_hit ? RESP_OKAY : RESP_SLVERR;
              rd_state     <= RD_DATA;
            end
          end else if (ar_start) begin
            s_axi_arready <= 1'b1;
          end
        end
        RD_WAIT: begin
          // RAM output is valid one cycle after the address
          s_axi_rvalid <= 1'b1;
          s_axi_rresp  <= RESP_OKAY;
          rd_state     <= RD_DATA;
        end
        RD_DATA: begin
          if (s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
            rd_state     <= RD_IDLE;
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge Clk) begin
    if (rd_fire) begin
      s_axi_rdata <= rd_reg_data;
    end else if (rd_state == RD_WAIT) begin
      s_axi_rdata <= {{(DW-12){1'b0}}, ram_rdata};
    end
  end

  bvalid_hold: assert property (@(posedge Clk) disable iff (!rst_n)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

  rdata_stable: assert property (@(posedge Clk) disable iff (!rst_n)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));

endmodule

/* source/gpu_pkg.sv */
`include "gpu_config.svh"

package gpu_pkg;

  // Register offsets on the bus side
  typedef enum logic [`GPU_ADDR_WIDTH-1:0] {
    REG_CTRL     = 'h000,
    REG_BG_COLOR = 'h004,
    REG_STATUS   = 'h008
  } reg_addr_e;

  typedef enum logic [0:0] {
    WR_IDLE,
    WR_RESP
  } wr_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT,
    RD_DATA
  } rd_state_e;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Raster coordinate and 4:4:4 color
  typedef logic [9:0] coord_t;
  typedef logic [11:0] rgb_t;

endpackage

/* source/gpu_config.svh */
`ifndef GPU_CONFIG_SVH
`define GPU_CONFIG_SVH

// Horizontal timing in pixel clocks
`define GPU_H_ACTIVE 128
`define GPU_H_FP 4
`define GPU_H_SYNC 8
`define GPU_H_BP 4

// Vertical timing in lines
`define GPU_V_ACTIVE 128
`define GPU_V_FP 2
`define GPU_V_SYNC 2
`define GPU_V_BP 2

// Tiles are 8x8 pixels, 16 per row
`define GPU_TILE_SHIFT 3
`define GPU_TILE_COLS 16
`define GPU_TILE_COUNT 256

// Bus widths and tile memory window
`define GPU_ADDR_WIDTH 13
`define GPU_DATA_WIDTH 32
`define GPU_VRAM_BASE 'h1000

`endif
